// ==== design/sync_pkg.sv ====
// cache geometry, host address map and the field select function
package sync_pkg;

  // line geometry
  localparam int WAY_W      = 2;                  // 4 ways
  localparam int BLK_W      = 4;                  // 16 blocks per way
  localparam int LINE_IDX_W = WAY_W + BLK_W;      // {way, blk}
  localparam int NUM_LINES  = 1 << LINE_IDX_W;    // 64 lines
  localparam int INFO_W     = 26;                 // tag/info word
  localparam int DATA_W     = 64;                 // line data

  // host address map
  localparam int WB_ADDR_W  = 9;                  // word address
  localparam int WB_DATA_W  = 32;
  localparam int FIELD_W    = 2;                  // adr[1:0]
  localparam int REGION_BIT = WB_ADDR_W - 1;      // adr[8]

  localparam logic [FIELD_W-1:0] FIELD_INFO = 2'd0;
  localparam logic [FIELD_W-1:0] FIELD_DLO  = 2'd1;
  localparam logic [FIELD_W-1:0] FIELD_DHI  = 2'd2;

  localparam logic REGION_ICACHE = 1'b1;          // 0 selects the dcache

  // picks one 32-bit host word out of a line
  function automatic logic [WB_DATA_W-1:0] field_sel(
    input logic [INFO_W-1:0]  info,
    input logic [DATA_W-1:0]  data,
    input logic [FIELD_W-1:0] field
  );
    logic [WB_DATA_W-1:0] word;
    case (field)
      FIELD_INFO: word = {{(WB_DATA_W - INFO_W){1'b0}}, info};  // zero extended
      FIELD_DLO:  word = data[WB_DATA_W-1:0];
      FIELD_DHI:  word = data[DATA_W-1:WB_DATA_W];
      default:    word = '0;                                     // unmapped field code
    endcase
    return word;
  endfunction

endpackage

// ==== design/dcache_store.sv ====
// data-cache line arrays, host field write/read and the sync line walker
`timescale 1ns/1ps

module dcache_store (
  input  logic                             clk,
  input  logic                             rst,
  // host side
  input  logic                             i_host_we,
  input  logic [sync_pkg::LINE_IDX_W-1:0]  i_host_idx,
  input  logic [sync_pkg::FIELD_W-1:0]     i_host_field,
  input  logic [sync_pkg::WB_DATA_W-1:0]   i_host_wdata,
  input  logic [sync_pkg::LINE_IDX_W-1:0]  i_host_ridx,
  output logic [sync_pkg::WB_DATA_W-1:0]   o_host_rdata,
  // sync side
  input  logic                             i_rreq,      // walk request level
  output logic                             o_rack,      // walk done pulse
  output logic                             o_rpackreq,  // packet valid
  input  logic                             i_rpackack,  // packet taken
  output logic [sync_pkg::WAY_W-1:0]       o_rwayid,
  output logic [sync_pkg::BLK_W-1:0]       o_rblkid,
  output logic [sync_pkg::INFO_W-1:0]      o_rinfo,
  output logic [sync_pkg::DATA_W-1:0]      o_rdata,
  output logic                             o_walk_busy
);

  typedef enum logic [1:0] {
    W_IDLE,   // waiting for rreq
    W_PACK,   // packet up, waiting for rpackack
    W_GAP,    // rpackreq low for one cycle between lines
    W_DONE    // rack sent, waiting for rreq to drop
  } walk_state_t;

  logic [sync_pkg::INFO_W-1:0] info_mem [sync_pkg::NUM_LINES];
  logic [sync_pkg::DATA_W-1:0] data_mem [sync_pkg::NUM_LINES];

  walk_state_t                    wstate;
  logic [sync_pkg::LINE_IDX_W-1:0] walk_idx;
  logic                            last_line;

  assign last_line = &walk_idx;  // line count fills the index range

  // host field writes, arrays start cleared
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < sync_pkg::NUM_LINES; i++) begin
        info_mem[i] <= '0;
        data_mem[i] <= '0;
      end
    end else if (i_host_we) begin
      case (i_host_field)
        sync_pkg::FIELD_INFO: info_mem[i_host_idx] <= i_host_wdata[sync_pkg::INFO_W-1:0];
        sync_pkg::FIELD_DLO:  data_mem[i_host_idx][sync_pkg::WB_DATA_W-1:0] <= i_host_wdata;
        sync_pkg::FIELD_DHI:
          data_mem[i_host_idx][sync_pkg::DATA_W-1:sync_pkg::WB_DATA_W] <= i_host_wdata;
        default: ;  // field 3 not mapped
      endcase
    end
  end

  // registered host read
  always_ff @(posedge clk) begin
    o_host_rdata <= sync_pkg::field_sel(info_mem[i_host_ridx], data_mem[i_host_ridx],
                                        i_host_field);
  end

  // walker, one packet in flight
  always_ff @(posedge clk) begin
    if (rst) begin
      wstate      <= W_IDLE;
      walk_idx    <= '0;
      o_rpackreq  <= 1'b0;
      o_rack      <= 1'b0;
      o_walk_busy <= 1'b0;
    end else begin
      case (wstate)
        W_IDLE: begin
          if (i_rreq) begin
            walk_idx    <= '0;
            o_rpackreq  <= 1'b1;  // line 0 goes up right away
            o_walk_busy <= 1'b1;
            wstate      <= W_PACK;
          end
        end
        W_PACK: begin
          if (i_rpackack) begin
            o_rpackreq <= 1'b0;
            if (last_line) begin
              o_rack <= 1'b1;
              wstate <= W_DONE;
            end else begin
              walk_idx <= walk_idx + 1'b1;
              wstate   <= W_GAP;
            end
          end
        end
        W_GAP: begin
          o_rpackreq <= 1'b1;  // next line
          wstate     <= W_PACK;
        end
        W_DONE: begin
          o_rack      <= 1'b0;  // single cycle
          o_walk_busy <= 1'b0;
          if (!i_rreq) wstate <= W_IDLE;
        end
        default: wstate <= W_IDLE;
      endcase
    end
  end

  // packet fields, stable while busy since host writes stall
  assign o_rwayid = walk_idx[sync_pkg::LINE_IDX_W-1 -: sync_pkg::WAY_W];
  assign o_rblkid = walk_idx[sync_pkg::BLK_W-1:0];
  assign o_rinfo  = info_mem[walk_idx];
  assign o_rdata  = data_mem[walk_idx];

endmodule

// ==== design/cache_sync.sv ====
// fence.i sync FSM moving dcache packets into the icache
`timescale 1ns/1ps

module cache_sync (
  input  logic                        clk,
  input  logic                        rst,
  // fence.i
  input  logic                        i_fencei_req,
  output logic                        o_fencei_ack,
  // dcache walker
  output logic                        o_dcache_rreq,
  input  logic                        i_dcache_rack,
  input  logic                        i_dcache_rpackreq,
  output logic                        o_dcache_rpackack,
  input  logic [sync_pkg::WAY_W-1:0]  i_dcache_rwayid,
  input  logic [sync_pkg::BLK_W-1:0]  i_dcache_rblkid,
  input  logic [sync_pkg::INFO_W-1:0] i_dcache_rinfo,
  input  logic [sync_pkg::DATA_W-1:0] i_dcache_rdata,
  // icache write
  output logic                        o_icache_wreq,
  input  logic                        i_icache_wack,
  output logic [sync_pkg::WAY_W-1:0]  o_icache_wwayid,
  output logic [sync_pkg::BLK_W-1:0]  o_icache_wblkid,
  output logic [sync_pkg::INFO_W-1:0] o_icache_winfo,
  output logic [sync_pkg::DATA_W-1:0] o_icache_wdata
);

  typedef enum logic [1:0] {
    ST_IDLE,        // no fence
    ST_SYNC_READ,   // rreq up and waiting for a packet or rack
    ST_SYNC_WRITE,  // packet out on wreq until wack
    ST_RPACK_ACK    // rpackack pulse then wait for rpackreq low
  } sync_state_t;

  sync_state_t state;
  logic        rd_done;  // walk finished
  logic        wr_done;  // icache took the line

  assign rd_done = o_dcache_rreq & i_dcache_rack;
  assign wr_done = o_icache_wreq & i_icache_wack;

  always_ff @(posedge clk) begin
    if (rst) begin
      state             <= ST_IDLE;
      o_fencei_ack      <= 1'b0;
      o_dcache_rreq     <= 1'b0;
      o_dcache_rpackack <= 1'b0;
      o_icache_wreq     <= 1'b0;
    end else begin
      o_fencei_ack <= 1'b0;  // one cycle pulse
      case (state)
        ST_IDLE: begin
          // a request still high during the ack cycle is the old fence
          if (i_fencei_req && !o_fencei_ack) state <= ST_SYNC_READ;
        end
        ST_SYNC_READ: begin
          if (rd_done) begin
            o_dcache_rreq <= 1'b0;
            o_fencei_ack  <= 1'b1;
            state         <= ST_IDLE;
          end else begin
            o_dcache_rreq <= 1'b1;
            if (i_dcache_rpackreq) state <= ST_SYNC_WRITE;  // packet latched below
          end
        end
        ST_SYNC_WRITE: begin
          if (wr_done) begin
            o_icache_wreq     <= 1'b0;
            o_dcache_rpackack <= 1'b1;
            state             <= ST_RPACK_ACK;
          end else begin
            o_icache_wreq <= 1'b1;
          end
        end
        ST_RPACK_ACK: begin
          o_dcache_rpackack <= 1'b0;
          if (rd_done) begin
            // rack comes with the drop of the last packet
            o_dcache_rreq <= 1'b0;
            o_fencei_ack  <= 1'b1;
            state         <= ST_IDLE;
          end else if (!i_dcache_rpackreq) begin
            state <= ST_SYNC_READ;  // walker moved on
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // write registers held through the wreq/wack exchange
  always_ff @(posedge clk) begin
    if (state == ST_SYNC_READ && i_dcache_rpackreq) begin
      o_icache_wwayid <= i_dcache_rwayid;
      o_icache_wblkid <= i_dcache_rblkid;
      o_icache_winfo  <= i_dcache_rinfo;
      o_icache_wdata  <= i_dcache_rdata;
    end
  end

endmodule

// ==== design/icache_store.sv ====
// instruction-cache line arrays with sync write port and host read port
`timescale 1ns/1ps

module icache_store (
  input  logic                            clk,
  input  logic                            rst,
  // sync write
  input  logic                            i_wreq,
  output logic                            o_wack,
  input  logic [sync_pkg::WAY_W-1:0]      i_wwayid,
  input  logic [sync_pkg::BLK_W-1:0]      i_wblkid,
  input  logic [sync_pkg::INFO_W-1:0]     i_winfo,
  input  logic [sync_pkg::DATA_W-1:0]     i_wdata,
  // host read
  input  logic [sync_pkg::LINE_IDX_W-1:0] i_ridx,
  input  logic [sync_pkg::FIELD_W-1:0]    i_rfield,
  output logic [sync_pkg::WB_DATA_W-1:0]  o_rdata
);

  logic [sync_pkg::INFO_W-1:0]     info_mem [sync_pkg::NUM_LINES];
  logic [sync_pkg::DATA_W-1:0]     data_mem [sync_pkg::NUM_LINES];
  logic [sync_pkg::LINE_IDX_W-1:0] widx;

  assign widx = {i_wwayid, i_wblkid};  // way in the upper bits

  always_ff @(posedge clk) begin
    if (rst) begin
      o_wack <= 1'b0;
      for (int i = 0; i < sync_pkg::NUM_LINES; i++) begin
        info_mem[i] <= '0;
        data_mem[i] <= '0;
      end
    end else begin
      o_wack <= i_wreq & ~o_wack;  // one cycle after wreq, then drops
      if (i_wreq && o_wack) begin   // write on the wack cycle
        info_mem[widx] <= i_winfo;
        data_mem[widx] <= i_wdata;
      end
    end
  end

  // registered field read
  always_ff @(posedge clk) begin
    o_rdata <= sync_pkg::field_sel(info_mem[i_ridx], data_mem[i_ridx], i_rfield);
  end

endmodule

// ==== design/host_wb_port.sv ====
// Wishbone classic slave decoding host accesses to both cache stores
`timescale 1ns/1ps

module host_wb_port (
  input  logic                            clk,
  input  logic                            rst,
  // Wishbone classic
  input  logic                            i_wb_cyc,
  input  logic                            i_wb_stb,
  input  logic                            i_wb_we,
  input  logic [sync_pkg::WB_ADDR_W-1:0]  i_wb_adr,
  input  logic [sync_pkg::WB_DATA_W-1:0]  i_wb_dat,
  output logic [sync_pkg::WB_DATA_W-1:0]  o_wb_dat,
  output logic                            o_wb_ack,
  input  logic                            i_walk_busy,
  // dcache host side
  output logic                            o_dc_we,
  output logic [sync_pkg::LINE_IDX_W-1:0] o_dc_idx,
  output logic [sync_pkg::FIELD_W-1:0]    o_dc_field,
  output logic [sync_pkg::WB_DATA_W-1:0]  o_dc_wdata,
  output logic [sync_pkg::LINE_IDX_W-1:0] o_dc_ridx,
  // icache host side
  output logic [sync_pkg::LINE_IDX_W-1:0] o_ic_ridx,
  output logic [sync_pkg::FIELD_W-1:0]    o_ic_rfield,
  input  logic [sync_pkg::WB_DATA_W-1:0]  i_dc_rdata,
  input  logic [sync_pkg::WB_DATA_W-1:0]  i_ic_rdata
);

  logic [sync_pkg::WB_ADDR_W-1:0] adr_q;   // read address capture
  logic                           rd_pend; // array read cycle
  logic                           req;     // new access, not yet in service
  logic                           live_ic; // current address hits the icache
  logic [sync_pkg::FIELD_W-1:0]   q_field;
  logic [sync_pkg::LINE_IDX_W-1:0] q_idx;

  assign req     = i_wb_cyc & i_wb_stb & ~o_wb_ack & ~rd_pend;
  assign live_ic = (i_wb_adr[sync_pkg::REGION_BIT] == sync_pkg::REGION_ICACHE);
  assign q_field = adr_q[sync_pkg::FIELD_W-1:0];
  assign q_idx   = adr_q[sync_pkg::FIELD_W +: sync_pkg::LINE_IDX_W];

  // writes go straight from the bus, dcache only, held off while walking
  assign o_dc_we    = req & i_wb_we & ~live_ic & ~i_walk_busy;
  assign o_dc_idx   = i_wb_adr[sync_pkg::FIELD_W +: sync_pkg::LINE_IDX_W];
  assign o_dc_wdata = i_wb_dat;
  assign o_dc_field = rd_pend ? q_field : i_wb_adr[sync_pkg::FIELD_W-1:0];

  // reads use the captured address
  assign o_dc_ridx   = q_idx;
  assign o_ic_ridx   = q_idx;
  assign o_ic_rfield = q_field;

  // return data from whichever store was addressed
  assign o_wb_dat = (adr_q[sync_pkg::REGION_BIT] == sync_pkg::REGION_ICACHE) ?
                    i_ic_rdata : i_dc_rdata;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_wb_ack <= 1'b0;
      rd_pend  <= 1'b0;
      adr_q    <= '0;
    end else begin
      o_wb_ack <= 1'b0;  // ack is a single cycle
      if (rd_pend) begin
        rd_pend  <= 1'b0;
        o_wb_ack <= i_wb_cyc & i_wb_stb;  // store data is valid now
      end else if (req && !i_wb_we) begin
        rd_pend <= 1'b1;
        adr_q   <= i_wb_adr;
      end else if (req && i_wb_we) begin
        // icache writes are dropped, dcache writes wait out the walk
        if (live_ic || !i_walk_busy) o_wb_ack <= 1'b1;
      end
    end
  end

endmodule

// ==== design/fencei_sync_top.sv ====
// top level wiring the dcache, sync engine, icache and host port
`timescale 1ns/1ps

module fencei_sync_top (
  input  logic                           clk,
  input  logic                           rst,
  // host Wishbone
  input  logic                           i_wb_cyc,
  input  logic                           i_wb_stb,
  input  logic                           i_wb_we,
  input  logic [sync_pkg::WB_ADDR_W-1:0] i_wb_adr,
  input  logic [sync_pkg::WB_DATA_W-1:0] i_wb_dat,
  output logic [sync_pkg::WB_DATA_W-1:0] o_wb_dat,
  output logic                           o_wb_ack,
  // fence.i
  input  logic                           i_fencei_req,
  output logic                           o_fencei_ack
);

  // host to stores
  logic                            dc_we;
  logic [sync_pkg::LINE_IDX_W-1:0] dc_idx;
  logic [sync_pkg::FIELD_W-1:0]    dc_field;
  logic [sync_pkg::WB_DATA_W-1:0]  dc_wdata;
  logic [sync_pkg::LINE_IDX_W-1:0] dc_ridx;
  logic [sync_pkg::WB_DATA_W-1:0]  dc_rdata;
  logic [sync_pkg::LINE_IDX_W-1:0] ic_ridx;
  logic [sync_pkg::FIELD_W-1:0]    ic_rfield;
  logic [sync_pkg::WB_DATA_W-1:0]  ic_rdata;
  logic                            walk_busy;

  // dcache walker to sync
  logic                            rreq;
  logic                            rack;
  logic                            rpackreq;
  logic                            rpackack;
  logic [sync_pkg::WAY_W-1:0]      rwayid;
  logic [sync_pkg::BLK_W-1:0]      rblkid;
  logic [sync_pkg::INFO_W-1:0]     rinfo;
  logic [sync_pkg::DATA_W-1:0]     rdata;

  // sync to icache
  logic                            wreq;
  logic                            wack;
  logic [sync_pkg::WAY_W-1:0]      wwayid;
  logic [sync_pkg::BLK_W-1:0]      wblkid;
  logic [sync_pkg::INFO_W-1:0]     winfo;
  logic [sync_pkg::DATA_W-1:0]     wdata;

  host_wb_port u_host (
    .clk(clk), .rst(rst),
    .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we),
    .i_wb_adr(i_wb_adr), .i_wb_dat(i_wb_dat), .o_wb_dat(o_wb_dat), .o_wb_ack(o_wb_ack),
    .i_walk_busy(walk_busy),
    .o_dc_we(dc_we), .o_dc_idx(dc_idx), .o_dc_field(dc_field), .o_dc_wdata(dc_wdata),
    .o_dc_ridx(dc_ridx), .o_ic_ridx(ic_ridx), .o_ic_rfield(ic_rfield),
    .i_dc_rdata(dc_rdata), .i_ic_rdata(ic_rdata)
  );

  dcache_store u_dcache (
    .clk(clk), .rst(rst),
    .i_host_we(dc_we), .i_host_idx(dc_idx), .i_host_field(dc_field),
    .i_host_wdata(dc_wdata), .i_host_ridx(dc_ridx), .o_host_rdata(dc_rdata),
    .i_rreq(rreq), .o_rack(rack), .o_rpackreq(rpackreq), .i_rpackack(rpackack),
    .o_rwayid(rwayid), .o_rblkid(rblkid), .o_rinfo(rinfo), .o_rdata(rdata),
    .o_walk_busy(walk_busy)
  );

  cache_sync u_sync (
    .clk(clk), .rst(rst),
    .i_fencei_req(i_fencei_req), .o_fencei_ack(o_fencei_ack),
    .o_dcache_rreq(rreq), .i_dcache_rack(rack),
    .i_dcache_rpackreq(rpackreq), .o_dcache_rpackack(rpackack),
    .i_dcache_rwayid(rwayid), .i_dcache_rblkid(rblkid),
    .i_dcache_rinfo(rinfo), .i_dcache_rdata(rdata),
    .o_icache_wreq(wreq), .i_icache_wack(wack),
    .o_icache_wwayid(wwayid), .o_icache_wblkid(wblkid),
    .o_icache_winfo(winfo), .o_icache_wdata(wdata)
  );

  icache_store u_icache (
    .clk(clk), .rst(rst),
    .i_wreq(wreq), .o_wack(wack),
    .i_wwayid(wwayid), .i_wblkid(wblkid), .i_winfo(winfo), .i_wdata(wdata),
    .i_ridx(ic_ridx), .i_rfield(ic_rfield), .o_rdata(ic_rdata)
  );

endmodule

// ==== tests/sync_checker.sv ====
// shadow dcache, expected icache image, bus watcher and read comparison
`timescale 1ns/1ps

module sync_checker (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           i_wb_cyc,
  input  logic                           i_wb_stb,
  input  logic                           i_wb_we,
  input  logic [sync_pkg::WB_ADDR_W-1:0] i_wb_adr,
  input  logic [sync_pkg::WB_DATA_W-1:0] i_wb_dat,
  input  logic [sync_pkg::WB_DATA_W-1:0] i_wb_rdat,  // DUT read data
  input  logic                           i_wb_ack,
  input  logic                           i_fencei_req,
  input  logic                           i_fencei_ack,
  output int                             o_checks,
  output int                             o_errors
);

  logic [sync_pkg::INFO_W-1:0] dc_info [sync_pkg::NUM_LINES];  // shadow dcache
  logic [sync_pkg::DATA_W-1:0] dc_data [sync_pkg::NUM_LINES];
  logic [sync_pkg::INFO_W-1:0] ic_info [sync_pkg::NUM_LINES];  // expected icache
  logic [sync_pkg::DATA_W-1:0] ic_data [sync_pkg::NUM_LINES];

  logic                            fence_open;
  logic                            ic_hit;
  logic [sync_pkg::LINE_IDX_W-1:0] idx;
  logic [sync_pkg::FIELD_W-1:0]    field;
  logic [sync_pkg::WB_DATA_W-1:0]  exp_word;
  int                              checks;
  int                              errors;

  // address map is adr[8] region, adr[7:2] {way, blk} and adr[1:0] field
  assign ic_hit   = (i_wb_adr[sync_pkg::REGION_BIT] == sync_pkg::REGION_ICACHE);
  assign idx      = i_wb_adr[sync_pkg::FIELD_W +: sync_pkg::LINE_IDX_W];
  assign field    = i_wb_adr[sync_pkg::FIELD_W-1:0];
  assign o_checks = checks;
  assign o_errors = errors;

  // what a host read of one field of one line must return
  function automatic logic [sync_pkg::WB_DATA_W-1:0] expected_word(
    input logic                            from_ic,
    input logic [sync_pkg::LINE_IDX_W-1:0] line,
    input logic [sync_pkg::FIELD_W-1:0]    fsel
  );
    logic [sync_pkg::INFO_W-1:0]    info;
    logic [sync_pkg::DATA_W-1:0]    data;
    logic [sync_pkg::WB_DATA_W-1:0] w;
    info = from_ic ? ic_info[line] : dc_info[line];
    data = from_ic ? ic_data[line] : dc_data[line];
    w    = '0;                               // upper info bits read as zero
    if (fsel == sync_pkg::FIELD_INFO) w[sync_pkg::INFO_W-1:0] = info;
    else if (fsel == sync_pkg::FIELD_DLO) w = data[31:0];
    else if (fsel == sync_pkg::FIELD_DHI) w = data[63:32];
    return w;
  endfunction

  task automatic flag(input string msg);
    errors++;
    $display("[FAIL] %0t ns: %s", $time, msg);
  endtask

  // falling edge sampling where DUT outputs and tb drives are settled
  always @(negedge clk) begin
    if (rst) begin
      for (int i = 0; i < sync_pkg::NUM_LINES; i++) begin
        dc_info[i] = '0;
        dc_data[i] = '0;
        ic_info[i] = '0;
        ic_data[i] = '0;
      end
      fence_open = 1'b0;
      checks     = 0;
      errors     = 0;
    end else begin
      if (i_wb_ack !== 1'b0 && !(i_wb_cyc && i_wb_stb)) begin
        flag($sformatf("Wishbone ack is %b with no request on the bus", i_wb_ack));
      end else if (i_wb_ack === 1'b1 && i_wb_we) begin
        if (!ic_hit) begin                   // icache region writes change nothing
          if (fence_open) flag($sformatf("dcache write to line %0d acked mid fence", idx));
          if (field == sync_pkg::FIELD_INFO) dc_info[idx] = i_wb_dat[sync_pkg::INFO_W-1:0];
          else if (field == sync_pkg::FIELD_DLO) dc_data[idx][31:0] = i_wb_dat;
          else if (field == sync_pkg::FIELD_DHI) dc_data[idx][63:32] = i_wb_dat;
        end
      end else if (i_wb_ack === 1'b1) begin
        checks++;
        exp_word = expected_word(ic_hit, idx, field);
        if (i_wb_rdat !== exp_word)
          flag($sformatf("%s read of line %0d field %0d gave 0x%h, expected 0x%h",
                         ic_hit ? "icache" : "dcache", idx, field, i_wb_rdat, exp_word));
      end
      if (i_fencei_ack !== 1'b0) begin
        if (!fence_open) begin
          flag($sformatf("fence ack is %b with no fence pending", i_fencei_ack));
        end else begin
          for (int i = 0; i < sync_pkg::NUM_LINES; i++) begin
            ic_info[i] = dc_info[i];         // walk done so the icache holds the dcache image
            ic_data[i] = dc_data[i];
          end
        end
        fence_open = 1'b0;
      end else if (i_fencei_req && !fence_open) begin
        fence_open = 1'b1;                   // dcache writes stall from here to the ack
      end
    end
  end

endmodule

// ==== tests/tb_top.sv ====
// clock, reset, LCG, Wishbone host tasks, fence stimulus, test sequence and run limit
`timescale 1ns/1ps

module tb_top;

  localparam int FENCE_CYCLES  = 3 * sync_pkg::NUM_LINES * 8;  // three fences at 8 clocks a line
  localparam int ACCESS_CYCLES = 1250 * 4;                      // ~1250 bus accesses of ~4 clocks
  localparam int RUN_LIMIT     = 2 * (FENCE_CYCLES + ACCESS_CYCLES);
  localparam int BUS_WAIT      = 16;                            // normal ack wait
  localparam int FENCE_WAIT    = sync_pkg::NUM_LINES * 8 + 64;
  localparam int NUM_TESTS     = 6;

  logic                           clk;
  logic                           rst;
  logic                           wb_cyc;
  logic                           wb_stb;
  logic                           wb_we;
  logic [sync_pkg::WB_ADDR_W-1:0] wb_adr;
  logic [sync_pkg::WB_DATA_W-1:0] wb_dat;
  logic [sync_pkg::WB_DATA_W-1:0] wb_rdat;
  logic                           wb_ack;
  logic                           fencei_req;
  logic                           fencei_ack;
  int                             chk_count;
  int                             chk_errors;
  int                             faults;      // timeouts seen by the tasks
  int                             cycles;
  int                             passed;
  int                             base_err;
  int                             base_chk;
  logic [31:0]                    rng;

  fencei_sync_top dut0 (
    .clk(clk), .rst(rst),
    .i_wb_cyc(wb_cyc), .i_wb_stb(wb_stb), .i_wb_we(wb_we), .i_wb_adr(wb_adr),
    .i_wb_dat(wb_dat), .o_wb_dat(wb_rdat), .o_wb_ack(wb_ack),
    .i_fencei_req(fencei_req), .o_fencei_ack(fencei_ack)
  );

  sync_checker chk0 (
    .clk(clk), .rst(rst),
    .i_wb_cyc(wb_cyc), .i_wb_stb(wb_stb), .i_wb_we(wb_we), .i_wb_adr(wb_adr),
    .i_wb_dat(wb_dat), .i_wb_rdat(wb_rdat), .i_wb_ack(wb_ack),
    .i_fencei_req(fencei_req), .i_fencei_ack(fencei_ack),
    .o_checks(chk_count), .o_errors(chk_errors)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  function automatic logic [31:0] next_rand();
    rng = rng * 32'd1664525 + 32'd1013904223;  // LCG step
    return rng;
  endfunction

  function automatic logic [sync_pkg::WB_ADDR_W-1:0] word_addr(
    input logic region, input logic [sync_pkg::LINE_IDX_W-1:0] line,
    input logic [sync_pkg::FIELD_W-1:0] fsel
  );
    return {region, line, fsel};
  endfunction

  // one classic cycle started 1 ns after a rising edge
  task automatic bus_access(input logic we, input logic [sync_pkg::WB_ADDR_W-1:0] adr,
                            input logic [31:0] dat, input int max_wait);
    int   n;
    logic acked;
    n      = 0;
    acked  = 1'b0;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = we;
    wb_adr = adr;
    wb_dat = dat;
    while (!acked && n < max_wait) begin
      @(posedge clk);
      #1;
      n++;
      acked = wb_ack;
    end
    @(posedge clk);  // stb held through the ack cycle
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    if (!acked) begin
      faults++;
      $display("error at %0t ns: Wishbone %s of address 0x%h got no ack within %0d cycles",
               $time, we ? "write" : "read", adr, max_wait);
    end
  endtask

  task automatic run_fence();
    int   n;
    logic seen;
    n          = 0;
    seen       = 1'b0;
    fencei_req = 1'b1;
    while (!seen && n < FENCE_WAIT) begin
      @(posedge clk);
      #1;
      n++;
      seen = fencei_ack;
    end
    fencei_req = 1'b0;  // dropped in the ack cycle
    if (!seen) begin
      faults++;
      $display("error at %0t ns: fence.i request got no ack within %0d cycles", $time, n);
    end
  endtask

  task automatic read_all(input logic region);
    for (int i = 0; i < sync_pkg::NUM_LINES; i++)
      for (int f = 0; f < 3; f++)
        bus_access(1'b0, word_addr(region, 6'(i), 2'(f)), '0, BUS_WAIT);
  endtask

  task automatic start_test();
    base_err = chk_errors + faults;
    base_chk = chk_count;
  endtask

  task automatic report_test(input int num, input string name);
    int errs;
    errs = chk_errors + faults - base_err;
    if (errs == 0) passed++;
    $display("test %0d %s: %s, %0d reads compared, %0d errors", num, name,
             errs == 0 ? "ok" : "FAILED", chk_count - base_chk, errs);
  endtask

  initial begin
    cycles = 0;
    while (cycles < RUN_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d clock cycles", RUN_LIMIT);
    $display("summary: %0d of %0d tests passed, %0d errors", passed, NUM_TESTS,
             chk_errors + faults);
    $display("tests failed");
    $finish;
  end

  initial begin
    logic [31:0] sel;
    rst        = 1'b1;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_dat     = '0;
    fencei_req = 1'b0;
    rng        = 32'd36;
    faults     = 0;
    passed     = 0;
    repeat (2) @(posedge clk);
    #1 rst = 1'b0;

    start_test();
    read_all(sync_pkg::REGION_ICACHE);  // cleared by reset
    report_test(1, "reset state");

    start_test();
    for (int i = 0; i < sync_pkg::NUM_LINES; i++)
      for (int f = 0; f < 3; f++)
        bus_access(1'b1, word_addr(1'b0, 6'(i), 2'(f)), next_rand(), BUS_WAIT);
    read_all(1'b0);
    report_test(2, "dcache write and readback");

    start_test();
    run_fence();
    read_all(sync_pkg::REGION_ICACHE);
    report_test(3, "fence copies every line");

    start_test();
    for (int i = 0; i < sync_pkg::NUM_LINES; i++) begin
      sel = next_rand();
      if (sel[31:30] == 2'b00)  // about a quarter of the lines
        for (int f = 0; f < 3; f++)
          bus_access(1'b1, word_addr(1'b0, 6'(i), 2'(f)), next_rand(), BUS_WAIT);
    end
    run_fence();
    read_all(sync_pkg::REGION_ICACHE);
    report_test(4, "second fence after partial rewrite");

    start_test();
    fork
      run_fence();
      begin
        repeat (4) @(posedge clk);  // walker busy by now
        #1;
        bus_access(1'b1, word_addr(1'b0, 6'd21, sync_pkg::FIELD_DLO), next_rand(),
                   FENCE_WAIT);
      end
    join
    bus_access(1'b0, word_addr(1'b0, 6'd21, sync_pkg::FIELD_DLO), '0, BUS_WAIT);
    bus_access(1'b0, word_addr(sync_pkg::REGION_ICACHE, 6'd21, sync_pkg::FIELD_DLO), '0,
               BUS_WAIT);
    report_test(5, "dcache write stalled by fence");

    start_test();
    for (int i = 0; i < 4; i++)
      for (int f = 0; f < 3; f++)
        bus_access(1'b1, word_addr(sync_pkg::REGION_ICACHE, 6'(i * 13), 2'(f)), next_rand(),
                   BUS_WAIT);
    read_all(sync_pkg::REGION_ICACHE);
    report_test(6, "icache writes ignored");

    $display("summary: %0d of %0d tests passed, %0d reads compared, %0d errors", passed,
             NUM_TESTS, chk_count, chk_errors + faults);
    if (chk_errors + faults == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
design/sync_pkg.sv
design/dcache_store.sv
design/cache_sync.sv
design/icache_store.sv
design/host_wb_port.sv
design/fencei_sync_top.sv
tests/sync_checker.sv
tests/tb_top.sv

// ==== Makefile ====
# Verilator build and run of the fence.i sync testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build tb_top with Verilator, run it, pass if the log has the pass line"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -j 0 --top-module tb_top -f sim.f --Mdir obj_dir
	./obj_dir/Vtb_top | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
